//--- bench/uart_cmd_bridge_checker.sv
`timescale 1ns/1ns

module uart_cmd_bridge_checker (
  input logic clk,
  input logic rst_n,
  input logic cmd_vld,
  input logic cmd_rdy,
  input logic tx,
  input logic read_rdy
);

  // line idles high while no command is in flight
  a_idle_high: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_rdy |-> tx)
    else $error("tx low while cmd_rdy is high");

  a_read_pulse: assert property (@(posedge clk) disable iff (!rst_n)
    read_rdy |=> !read_rdy)
    else $error("read_rdy high for two cycles in a row");

  a_rdy_drop: assert property (@(posedge clk) disable iff (!rst_n)
    cmd_vld && cmd_rdy |=> !cmd_rdy)
    else $error("cmd_rdy still high after a transfer");

endmodule

//--- bench/uart_cmd_bridge_tb.sv
`timescale 1ns/1ns

module uart_cmd_bridge_tb;

  localparam int N_CMD = 23;
  localparam int N_RX = 24;
  localparam int MIN_GAP = 22 * uart_pkg::BIT_CYCLES + 2;
  // all frames end to end, plus 20%
  localparam int TIMEOUT = (2 * N_CMD + N_RX) * 11 * uart_pkg::BIT_CYCLES * 12 / 10;

  logic           clk = 1'b0;
  logic           rst_n = 1'b0;
  cmd_pkg::cmd_t  cmd;
  logic           cmd_vld;
  logic           cmd_rdy;
  logic           rx;
  logic           tx;
  logic           read_rdy;
  cmd_pkg::read_t read_data;

  logic [10:0]    exp_q[$];
  logic [10:0]    got_q[$];
  cmd_pkg::read_t rexp_q[$];
  int             cyc = 0;
  int             last_accept = -1;

  uart_cmd_bridge UUT (.*);

  bind uart_cmd_bridge uart_cmd_bridge_checker u_checker (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx       (tx),
    .read_rdy (read_rdy)
  );

  always #2 clk = ~clk;

  // frame in line order: start, data lsb first, odd parity, stop
  function automatic logic [10:0] ref_frame(input uart_pkg::byte_t b);
    int   ones;
    logic par;
    ones = 0;
    for (int i = 0; i < 8; i++) begin
      if (b[i]) begin
        ones++;
      end
    end
    par = (ones % 2 == 0);
    return {1'b1, par, b, 1'b0};
  endfunction

  function automatic cmd_pkg::read_t ref_read(input uart_pkg::byte_t b, input logic bad_par,
                                              input logic bad_stop);
    cmd_pkg::read_t r;
    r.data = b;
    r.parity_err = bad_par;
    r.frame_err = bad_stop;
    return r;
  endfunction

  task automatic fail_run(input string msg);
    $display("%s", msg);
    $display("Finished with errors");
    $fatal(1);
  endtask

  task automatic send_cmd(input cmd_pkg::cmd_t c);
    cmd = c;
    cmd_vld = 1'b1;
    while (!cmd_rdy) begin
      @(negedge clk);
    end
    // transfer happens on the next rising edge
    if (last_accept >= 0) begin
      assert (cyc - last_accept >= MIN_GAP) else begin
        fail_run($sformatf("ERR %0t ns: commands accepted %0d cycles apart", $time,
                           cyc - last_accept));
      end
    end
    last_accept = cyc;
    exp_q.push_back(ref_frame(c.hi));
    exp_q.push_back(ref_frame(c.lo));
    @(negedge clk);
    cmd_vld = 1'b0;
  endtask

  task automatic send_frame(input uart_pkg::byte_t b, input logic bad_par, input logic bad_stop);
    logic [10:0] f;
    f = ref_frame(b);
    if (bad_par) begin
      f[9] = ~f[9];
    end
    if (bad_stop) begin
      f[10] = 1'b0;
    end
    rexp_q.push_back(ref_read(b, bad_par, bad_stop));
    for (int i = 0; i < 11; i++) begin
      rx = f[i];
      repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
    end
    rx = 1'b1;
  endtask

  // tx monitor, samples mid-bit after a falling edge
  initial begin
    logic [10:0] bits;
    wait (rst_n === 1'b1);
    forever begin
      @(negedge clk);
      if (tx === 1'b0) begin
        repeat (uart_pkg::BIT_CYCLES / 2) @(negedge clk);
        bits[0] = tx;
        for (int i = 1; i < 11; i++) begin
          repeat (uart_pkg::BIT_CYCLES) @(negedge clk);
          bits[i] = tx;
        end
        got_q.push_back(bits);
      end
    end
  end

  always @(posedge clk) begin
    logic [10:0] got;
    logic [10:0] want;
    if (got_q.size() > 0) begin
      got = got_q.pop_front();
      assert (exp_q.size() > 0) else begin
        fail_run("a frame appeared on tx without an accepted command");
      end
      want = exp_q.pop_front();
      assert (got === want) else begin
        fail_run($sformatf("ERR %0t ns: tx frame %b, expected %b", $time, got, want));
      end
    end
  end

  always @(negedge clk) begin
    cmd_pkg::read_t want_r;
    if (rst_n && read_rdy) begin
      assert (rexp_q.size() > 0) else begin
        fail_run("read_rdy pulsed without a frame sent on rx");
      end
      want_r = rexp_q.pop_front();
      assert (read_data === want_r) else begin
        fail_run($sformatf("ERR %0t ns: read_data %h, expected %h", $time, read_data, want_r));
      end
    end
  end

  always @(posedge clk) begin
    cyc <= cyc + 1;
    if (cyc >= TIMEOUT) begin
      fail_run($sformatf("timeout, the run did not finish within %0d cycles", TIMEOUT));
    end
  end

  initial begin
    logic [31:0] r_tx;
    logic [31:0] r_rx;
    void'($urandom(32'h21ce));
    rst_n = 1'b0;
    cmd = '0;
    cmd_vld = 1'b0;
    rx = 1'b1;
    repeat (3) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    @(negedge clk);
    assert (tx === 1'b1 && cmd_rdy === 1'b1) else begin
      fail_run($sformatf("ERR %0t ns: after reset tx=%b cmd_rdy=%b", $time, tx, cmd_rdy));
    end
    fork
      begin
        for (int i = 0; i < N_CMD; i++) begin
          r_tx = $urandom;
          send_cmd(r_tx[15:0]);
          // last three commands wait with cmd_vld held high
          if (i < N_CMD - 3) begin
            repeat ($urandom_range(0, 33 * uart_pkg::BIT_CYCLES)) @(negedge clk);
          end
        end
      end
      begin
        for (int i = 0; i < N_RX; i++) begin
          repeat ($urandom_range(1, 60)) @(negedge clk);
          r_rx = $urandom;
          send_frame(r_rx[7:0], i % 4 == 2, i % 4 == 3);
        end
      end
    join
    while (exp_q.size() > 0 || got_q.size() > 0 || rexp_q.size() > 0) begin
      @(negedge clk);
    end
    $display("Finished with no errors");
    $finish;
  end

endmodule

//--- common/cmd_pkg.sv
package cmd_pkg;

  // 16-bit command, high byte goes out first
  typedef struct packed {
    uart_pkg::byte_t hi;
    uart_pkg::byte_t lo;
  } cmd_t;

  // one received byte with its error flags
  typedef struct packed {
    uart_pkg::byte_t data;
    logic            parity_err;
    logic            frame_err;
  } read_t;

  typedef enum logic [1:0] {
    send_idle,
    send_high,
    send_low
  } sender_state_e;

endpackage

//--- common/uart_pkg.sv
package uart_pkg;

  // line timing for a 50 MHz system clock
  localparam int unsigned CLK_HZ = 50_000_000;
  localparam int unsigned BAUD = 115_200;

  // 434 clocks per bit
  localparam int unsigned BIT_CYCLES = CLK_HZ / BAUD;

  localparam int unsigned DATA_BITS = 8;

  // counter widths for the serial blocks
  localparam int unsigned CNT_W = $clog2(BIT_CYCLES);
  localparam int unsigned IDX_W = $clog2(DATA_BITS);

  typedef logic [DATA_BITS-1:0] byte_t;

  // position inside one serial frame
  typedef enum logic [2:0] {
    frame_idle,
    frame_start,
    frame_data,
    frame_parity,
    frame_stop
  } frame_state_e;

endpackage

//--- rtl/cmd_sender.sv
`timescale 1ns/1ns

module cmd_sender (
  input  logic            clk,
  input  logic            rst_n,
  input  cmd_pkg::cmd_t   cmd,
  input  logic            cmd_vld,
  output logic            cmd_rdy,
  output uart_pkg::byte_t tx_byte,
  output logic            tx_start,
  input  logic            tx_done
);

  cmd_pkg::sender_state_e state;
  cmd_pkg::sender_state_e state_nxt;
  cmd_pkg::cmd_t          cmd_q;
  logic                   start_nxt;
  logic                   accept;

  assign accept = cmd_vld && cmd_rdy;

  always_comb begin
    state_nxt = state;
    start_nxt = 1'b0;
    case (state)
      cmd_pkg::send_idle: begin
        if (accept) begin
          state_nxt = cmd_pkg::send_high;
          start_nxt = 1'b1;
        end
      end
      cmd_pkg::send_high: begin
        // high byte done, low byte next
        if (tx_done) begin
          state_nxt = cmd_pkg::send_low;
          start_nxt = 1'b1;
        end
      end
      cmd_pkg::send_low: begin
        if (tx_done) begin
          state_nxt = cmd_pkg::send_idle;
        end
      end
      default: state_nxt = cmd_pkg::send_idle;
    endcase
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= cmd_pkg::send_idle;
      tx_start <= 1'b0;
      cmd_rdy  <= 1'b1;
    end else begin
      state    <= state_nxt;
      tx_start <= start_nxt;
      cmd_rdy  <= (state_nxt == cmd_pkg::send_idle);
    end
  end

  always_ff @(posedge clk) begin
    if (accept) begin
      cmd_q <= cmd;
    end
  end

  assign tx_byte = (state == cmd_pkg::send_low) ? cmd_q.lo : cmd_q.hi;

endmodule

//--- rtl/uart_cmd_bridge.sv
`timescale 1ns/1ns

module uart_cmd_bridge (
  input  logic           clk,
  input  logic           rst_n,
  input  cmd_pkg::cmd_t  cmd,
  input  logic           cmd_vld,
  output logic           cmd_rdy,
  input  logic           rx,
  output logic           tx,
  output logic           read_rdy,
  output cmd_pkg::read_t read_data
);

  uart_pkg::byte_t tx_byte;
  logic            tx_start;
  logic            tx_done;

  // command to byte sequencing
  cmd_sender u_cmd_sender (
    .clk      (clk),
    .rst_n    (rst_n),
    .cmd      (cmd),
    .cmd_vld  (cmd_vld),
    .cmd_rdy  (cmd_rdy),
    .tx_byte  (tx_byte),
    .tx_done  (tx_done),
    .tx_start (tx_start)
  );

  uart_tx u_uart_tx (
    .clk      (clk),
    .rst_n    (rst_n),
    .tx_byte  (tx_byte),
    .tx_start (tx_start),
    .tx_done  (tx_done),
    .tx       (tx)
  );

  uart_rx u_uart_rx (
    .clk       (clk),
    .rst_n     (rst_n),
    .rx        (rx),
    .read_rdy  (read_rdy),
    .read_data (read_data)
  );

endmodule

//--- run_sim.sh
#!/bin/sh
# compile and run the testbench with Verilator, verdict from the log
rm -rf obj_dir sim.log
verilator --binary --timing --assert -f uart_cmd_bridge.f \
  --top-module uart_cmd_bridge_tb -o uart_cmd_bridge_sim > sim.log 2>&1 &&
  ./obj_dir/uart_cmd_bridge_sim >> sim.log 2>&1 ||
  echo "build or simulation exited with an error" >> sim.log
grep -q "Finished with errors" sim.log && { echo "FAIL"; exit 1; }
grep -q "Finished with no errors" sim.log || { echo "FAIL"; exit 1; }
echo "PASS"
exit 0

//--- uart/uart_rx.sv
`timescale 1ns/1ns

module uart_rx (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          rx,
  output logic          read_rdy,
  output cmd_pkg::read_t read_data
);

  logic                       rx_meta;
  logic                       rx_sync;
  logic                       rx_prev;
  uart_pkg::frame_state_e     state;
  logic [uart_pkg::CNT_W-1:0] bit_cnt;
  logic [uart_pkg::IDX_W-1:0] bit_idx;
  uart_pkg::byte_t            shift_q;
  logic                       parity_q;
  logic                       start_edge;
  logic                       half_end;
  logic                       bit_end;

  // two-flop synchronizer plus one flop for edge detection
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      rx_meta <= 1'b1;
      rx_sync <= 1'b1;
      rx_prev <= 1'b1;
    end else begin
      rx_meta <= rx;
      rx_sync <= rx_meta;
      rx_prev <= rx_sync;
    end
  end

  assign start_edge = rx_prev && !rx_sync;
  assign half_end = (bit_cnt == uart_pkg::CNT_W'(uart_pkg::BIT_CYCLES / 2 - 1));
  assign bit_end = (bit_cnt == uart_pkg::CNT_W'(uart_pkg::BIT_CYCLES - 1));

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state    <= uart_pkg::frame_idle;
      bit_cnt  <= '0;
      bit_idx  <= '0;
      read_rdy <= 1'b0;
    end else begin
      read_rdy <= 1'b0;
      bit_cnt  <= bit_cnt + 1'b1;
      case (state)
        uart_pkg::frame_idle: begin
          bit_cnt <= '0;
          if (start_edge) begin
            state <= uart_pkg::frame_start;
          end
        end
        uart_pkg::frame_start: begin
          // mid start bit, high again means a glitch
          if (half_end) begin
            bit_cnt <= '0;
            bit_idx <= '0;
            state   <= rx_sync ? uart_pkg::frame_idle : uart_pkg::frame_data;
          end
        end
        uart_pkg::frame_data: begin
          if (bit_end) begin
            bit_cnt <= '0;
            if (bit_idx == uart_pkg::IDX_W'(uart_pkg::DATA_BITS - 1)) begin
              state <= uart_pkg::frame_parity;
            end else begin
              bit_idx <= bit_idx + 1'b1;
            end
          end
        end
        uart_pkg::frame_parity: begin
          if (bit_end) begin
            bit_cnt <= '0;
            state   <= uart_pkg::frame_stop;
          end
        end
        uart_pkg::frame_stop: begin
          if (bit_end) begin
            state    <= uart_pkg::frame_idle;
            read_rdy <= 1'b1;
          end
        end
        default: state <= uart_pkg::frame_idle;
      endcase
    end
  end

  // samples taken mid-bit
  always_ff @(posedge clk) begin
    if (bit_end && state == uart_pkg::frame_data) begin
      shift_q <= {rx_sync, shift_q[uart_pkg::DATA_BITS-1:1]};
    end
    if (bit_end && state == uart_pkg::frame_parity) begin
      parity_q <= rx_sync;
    end
    if (bit_end && state == uart_pkg::frame_stop) begin
      read_data.data       <= shift_q;
      read_data.parity_err <= ~^{shift_q, parity_q};
      read_data.frame_err  <= !rx_sync;
    end
  end

endmodule

//--- uart/uart_tx.sv
`timescale 1ns/1ns

module uart_tx (
  input  logic            clk,
  input  logic            rst_n,
  input  uart_pkg::byte_t tx_byte,
  input  logic            tx_start,
  output logic            tx_done,
  output logic            tx
);

  uart_pkg::frame_state_e     state;
  logic [uart_pkg::CNT_W-1:0] bit_cnt;
  logic [uart_pkg::IDX_W-1:0] bit_idx;
  uart_pkg::byte_t            shift_q;
  logic                       parity_q;
  logic                       bit_end;

  assign bit_end = (bit_cnt == uart_pkg::CNT_W'(uart_pkg::BIT_CYCLES - 1));

  // high during the last clock of the stop bit
  assign tx_done = (state == uart_pkg::frame_stop) && bit_end;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state   <= uart_pkg::frame_idle;
      bit_cnt <= '0;
      bit_idx <= '0;
      tx      <= 1'b1;
    end else if (state == uart_pkg::frame_idle) begin
      bit_cnt <= '0;
      if (tx_start) begin
        state <= uart_pkg::frame_start;
        tx    <= 1'b0;
      end
    end else if (!bit_end) begin
      bit_cnt <= bit_cnt + 1'b1;
    end else begin
      bit_cnt <= '0;
      case (state)
        uart_pkg::frame_start: begin
          state   <= uart_pkg::frame_data;
          bit_idx <= '0;
          tx      <= shift_q[0];
        end
        uart_pkg::frame_data: begin
          if (bit_idx == uart_pkg::IDX_W'(uart_pkg::DATA_BITS - 1)) begin
            state <= uart_pkg::frame_parity;
            tx    <= parity_q;
          end else begin
            bit_idx <= bit_idx + 1'b1;
            tx      <= shift_q[0];
          end
        end
        uart_pkg::frame_parity: begin
          state <= uart_pkg::frame_stop;
          tx    <= 1'b1;
        end
        default: begin
          // end of stop bit, line stays high
          state <= uart_pkg::frame_idle;
          tx    <= 1'b1;
        end
      endcase
    end
  end

  // byte and odd parity latched at start, lsb first
  always_ff @(posedge clk) begin
    if (state == uart_pkg::frame_idle && tx_start) begin
      shift_q  <= tx_byte;
      parity_q <= ~^tx_byte;
    end else if (bit_end && (state == uart_pkg::frame_start ||
                             state == uart_pkg::frame_data)) begin
      shift_q <= shift_q >> 1;
    end
  end

endmodule

//--- uart_cmd_bridge.f
common/uart_pkg.sv
common/cmd_pkg.sv
uart/uart_tx.sv
uart/uart_rx.sv
rtl/cmd_sender.sv
rtl/uart_cmd_bridge.sv
bench/uart_cmd_bridge_checker.sv
bench/uart_cmd_bridge_tb.sv
